/* hw/saturnBusPkg.sv */
package saturnBusPkg;

	// CPU bus
	typedef logic [24:0] cpuAddrT;
	typedef logic [31:0] cpuDataT;

	// Byte lane strobes, low active
	typedef logic [3:0] dqmT;

	// Shared by the B-bus and the A-bus
	typedef logic [15:0] bBusDataT;

	typedef logic [7:0] smpcDataT;

	typedef logic [7:0] waitCntT;

	// Address fetched early in the boot ROM
	parameter cpuAddrT defaultHookAddr = 25'h00012B0;

endpackage

/* hw/saturnCtrlPkg.sv */
package saturnCtrlPkg;

	// Debug run control
	typedef enum logic [1:0] {
		rsIdle,
		rsRun,
		rsBreak
	} runStateT;

	typedef logic [2:0] smpcDivT;

	// Rising phases per SMPC enable
	parameter smpcDivT defaultSmpcDivide = 3'd7;

endpackage

/* hw/clockEnableGen.sv */
`timescale 1ns/100ps

module clockEnableGen (
	input  logic CLK,
	input  logic RST_N,
	input  logic ce,
	input  logic cdCe,
	input  logic dbgPause,
	input  logic dbgBreak,
	input  logic dbgRun,
	input  logic vdp1Start,
	input  logic vdp1CmdEnd,
	output logic ceR,
	output logic ceF,
	output logic cdCeR,
	output logic cdCeF,
	output logic pause
);

	import saturnCtrlPkg::*;

	runStateT runState;
	runStateT runStateNext;
	logic mclk;
	logic cdClk;

	// Drawing events halt only when the debugger asks for it
	always_comb begin
		runStateNext = runState;
		if (vdp1Start) begin
			runStateNext = dbgBreak ? rsBreak : rsRun;
		end else if (vdp1CmdEnd && runState != rsIdle) begin
			runStateNext = dbgBreak ? rsBreak : rsRun;
		end else if (dbgRun && runState == rsBreak) begin
			runStateNext = rsRun;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			runState <= rsIdle;
		end else begin
			runState <= runStateNext;
		end
	end

	assign pause = dbgPause | (runState == rsBreak);

	// Master clock phase, frozen while paused
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mclk <= 1'b0;
		end else if (ce && !pause) begin
			mclk <= ~mclk;
		end
	end

	assign ceR = mclk & ~pause;
	assign ceF = ~mclk & ~pause;

	// CD subsystem runs off its own enable, never paused
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cdClk <= 1'b0;
		end else if (cdCe) begin
			cdClk <= ~cdClk;
		end
	end

	assign cdCeR = cdClk & cdCe;
	assign cdCeF = ~cdClk & cdCe;

endmodule

/* hw/smpcClockDiv.sv */
`timescale 1ns/100ps

module smpcClockDiv #(
	parameter saturnCtrlPkg::smpcDivT smpcDivide = saturnCtrlPkg::defaultSmpcDivide
) (
	input  logic CLK,
	input  logic RST_N,
	input  logic ceR,
	output logic smpcCe,
	output logic mresN
);

	import saturnCtrlPkg::*;

	smpcDivT divCnt;
	smpcDivT divCntNext;

	assign divCntNext = divCnt + smpcDivT'(1);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			divCnt <= '0;
			smpcCe <= 1'b0;
			mresN <= 1'b0;
		end else begin
			smpcCe <= 1'b0;
			if (ceR) begin
				divCnt <= divCntNext;
				if (divCntNext == smpcDivide) begin
					divCnt <= '0;
					smpcCe <= 1'b1;
				end
			end

			// Master reset released after the first SMPC tick, then held
			if (smpcCe) begin
				mresN <= 1'b1;
			end
		end
	end

endmodule

/* hw/busReadMux.sv */
`timescale 1ns/100ps

module busReadMux (
	input  logic                  cpuCs3N,
	input  logic                  dramCeN,
	input  logic                  romCeN,
	input  logic                  sramCeN,
	input  logic                  smpcCeN,
	input  saturnBusPkg::cpuDataT  memDataIn,
	input  saturnBusPkg::cpuDataT  scuData,
	input  saturnBusPkg::smpcDataT smpcData,
	input  logic                  scuWaitN,
	input  logic                  memWaitN,
	input  logic                  bCs1N,
	input  logic                  bCs2N,
	input  logic                  bCssN,
	input  logic                  aCs2N,
	input  saturnBusPkg::bBusDataT vdp1Data,
	input  saturnBusPkg::bBusDataT vdp2Data,
	input  saturnBusPkg::bBusDataT scspData,
	input  saturnBusPkg::bBusDataT cdData,
	output saturnBusPkg::cpuDataT  cpuDataIn,
	output logic                  cpuWaitN,
	output saturnBusPkg::bBusDataT bDataIn,
	output saturnBusPkg::bBusDataT aDataIn
);

	import saturnBusPkg::*;

	logic memSel;
	cpuDataT smpcWord;

	// Any of the external memories is selected
	assign memSel = ~(cpuCs3N & dramCeN & romCeN & sramCeN);

	// SMPC registers are byte wide, mirrored on every lane
	assign smpcWord = {4{smpcData}};

	always_comb begin
		if (memSel) begin
			cpuDataIn = memDataIn;
		end else if (!smpcCeN) begin
			cpuDataIn = smpcWord;
		end else begin
			cpuDataIn = scuData;
		end
	end

	// Memory wait only counts during a memory access
	assign cpuWaitN = scuWaitN & (memWaitN | ~memSel);

	always_comb begin
		if (!bCs1N) begin
			bDataIn = vdp1Data;
		end else if (!bCs2N) begin
			bDataIn = vdp2Data;
		end else if (!bCssN) begin
			bDataIn = scspData;
		end else begin
			bDataIn = '0;
		end
	end

	// Only the CD block sits on the A-bus here
	assign aDataIn = !aCs2N ? cdData : bBusDataT'(0);

endmodule

/* hw/debugMonitor.sv */
`timescale 1ns/100ps

module debugMonitor #(
	parameter saturnBusPkg::cpuAddrT hookAddr = saturnBusPkg::defaultHookAddr
) (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 ceR,
	input  logic                 cpuRdN,
	input  logic                 cpuCs3N,
	input  saturnBusPkg::cpuAddrT cpuAddr,
	input  saturnBusPkg::dqmT     cpuDqmN,
	output saturnBusPkg::waitCntT dbgWaitCnt,
	output logic                 dbgHook
);

	import saturnBusPkg::*;

	logic busIdle;
	logic hookHit;

	// No read and no byte lane strobed
	assign busIdle = cpuRdN & (&cpuDqmN);

	assign hookHit = (cpuAddr == hookAddr) & ~cpuRdN & ~cpuCs3N;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dbgWaitCnt <= '0;
			dbgHook <= 1'b0;
		end else if (ceR) begin
			if (busIdle) begin
				dbgWaitCnt <= '0;
			end else begin
				dbgWaitCnt <= dbgWaitCnt + waitCntT'(1);
			end

			// Sticky until reset
			if (hookHit) begin
				dbgHook <= 1'b1;
			end
		end
	end

endmodule

/* hw/saturnGlue.sv */
`timescale 1ns/100ps

module saturnGlue #(
	parameter saturnCtrlPkg::smpcDivT smpcDivide = saturnCtrlPkg::defaultSmpcDivide,
	parameter saturnBusPkg::cpuAddrT hookAddr = saturnBusPkg::defaultHookAddr
) (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  ce,
	input  logic                  cdCe,
	input  logic                  dbgPause,
	input  logic                  dbgBreak,
	input  logic                  dbgRun,
	input  logic                  vdp1Start,
	input  logic                  vdp1CmdEnd,
	output logic                  ceR,
	output logic                  ceF,
	output logic                  cdCeR,
	output logic                  cdCeF,
	output logic                  pause,
	output logic                  smpcCe,
	output logic                  mresN,

	input  saturnBusPkg::cpuAddrT  cpuAddr,
	input  saturnBusPkg::cpuDataT  cpuDataOut,
	input  saturnBusPkg::dqmT      cpuDqmN,
	input  logic                  cpuRdN,
	input  logic                  cpuCs3N,
	input  logic                  dramCeN,
	input  logic                  romCeN,
	input  logic                  sramCeN,
	input  logic                  smpcCeN,
	input  saturnBusPkg::cpuDataT  memDataIn,
	input  saturnBusPkg::cpuDataT  scuData,
	input  saturnBusPkg::smpcDataT smpcData,
	input  logic                  scuWaitN,
	input  logic                  memWaitN,
	output saturnBusPkg::cpuDataT  cpuDataIn,
	output logic                  cpuWaitN,

	input  logic                  bCs1N,
	input  logic                  bCs2N,
	input  logic                  bCssN,
	input  logic                  aCs2N,
	input  saturnBusPkg::bBusDataT vdp1Data,
	input  saturnBusPkg::bBusDataT vdp2Data,
	input  saturnBusPkg::bBusDataT scspData,
	input  saturnBusPkg::bBusDataT cdData,
	output saturnBusPkg::bBusDataT bDataIn,
	output saturnBusPkg::bBusDataT aDataIn,

	output saturnBusPkg::cpuAddrT  memAddr,
	output saturnBusPkg::cpuDataT  memDataOut,
	output saturnBusPkg::dqmT      memDqmN,
	output logic                  memRdN,
	output logic                  romCsN,
	output logic                  sramCsN,
	output logic                  ramlCsN,
	output logic                  ramhCsN,

	output saturnBusPkg::waitCntT  dbgWaitCnt,
	output logic                  dbgHook
);

	clockEnableGen clockEnableGen_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.ce(ce),
		.cdCe(cdCe),
		.dbgPause(dbgPause),
		.dbgBreak(dbgBreak),
		.dbgRun(dbgRun),
		.vdp1Start(vdp1Start),
		.vdp1CmdEnd(vdp1CmdEnd),
		.ceR(ceR),
		.ceF(ceF),
		.cdCeR(cdCeR),
		.cdCeF(cdCeF),
		.pause(pause)
	);

	smpcClockDiv #(
		.smpcDivide(smpcDivide)
	) smpcClockDiv_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.ceR(ceR),
		.smpcCe(smpcCe),
		.mresN(mresN)
	);

	busReadMux busReadMux_i (
		.cpuCs3N(cpuCs3N),
		.dramCeN(dramCeN),
		.romCeN(romCeN),
		.sramCeN(sramCeN),
		.smpcCeN(smpcCeN),
		.memDataIn(memDataIn),
		.scuData(scuData),
		.smpcData(smpcData),
		.scuWaitN(scuWaitN),
		.memWaitN(memWaitN),
		.bCs1N(bCs1N),
		.bCs2N(bCs2N),
		.bCssN(bCssN),
		.aCs2N(aCs2N),
		.vdp1Data(vdp1Data),
		.vdp2Data(vdp2Data),
		.scspData(scspData),
		.cdData(cdData),
		.cpuDataIn(cpuDataIn),
		.cpuWaitN(cpuWaitN),
		.bDataIn(bDataIn),
		.aDataIn(aDataIn)
	);

	debugMonitor #(
		.hookAddr(hookAddr)
	) debugMonitor_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.ceR(ceR),
		.cpuRdN(cpuRdN),
		.cpuCs3N(cpuCs3N),
		.cpuAddr(cpuAddr),
		.cpuDqmN(cpuDqmN),
		.dbgWaitCnt(dbgWaitCnt),
		.dbgHook(dbgHook)
	);

	// Memory side follows the CPU bus directly
	assign memAddr = cpuAddr;
	assign memDataOut = cpuDataOut;
	assign memDqmN = cpuDqmN;
	assign memRdN = cpuRdN;

	// Chip select mapping
	assign romCsN = romCeN;
	assign sramCsN = sramCeN;
	assign ramlCsN = dramCeN;
	assign ramhCsN = cpuCs3N;

endmodule

/* tests/saturnGlueTb.sv */
`timescale 1ns/100ps

module saturnGlueTb;

	import saturnBusPkg::*;
	import saturnCtrlPkg::*;

	localparam int waitLimit = 200;

	logic CLK, RST_N, ce, cdCe, dbgPause, dbgBreak, dbgRun, vdp1Start, vdp1CmdEnd;
	logic ceR, ceF, cdCeR, cdCeF, pause, smpcCe, mresN;
	cpuAddrT cpuAddr, memAddr;
	cpuDataT cpuDataOut, memDataIn, scuData, cpuDataIn, memDataOut;
	dqmT cpuDqmN, memDqmN;
	logic cpuRdN, cpuCs3N, dramCeN, romCeN, sramCeN, smpcCeN;
	logic scuWaitN, memWaitN, cpuWaitN;
	smpcDataT smpcData;
	logic bCs1N, bCs2N, bCssN, aCs2N;
	bBusDataT vdp1Data, vdp2Data, scspData, cdData, bDataIn, aDataIn;
	logic memRdN, romCsN, sramCsN, ramlCsN, ramhCsN;
	waitCntT dbgWaitCnt;
	logic dbgHook;

	logic [31:0] lcgState;
	logic [16:0] muxTable [0:9];

	saturnGlue saturnGlue_i (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// Upper bound on the whole run
	initial begin
		#100000;
		reportFailure("Simulation did not finish within 100 us");
	end

	function logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			reportFailure($sformatf("** Error %s: expected %0h, actual %0h",
				testName, expected, actual));
		end
	endtask

	task automatic nextCycle();
		@(posedge CLK);
		#2;
	endtask

	task automatic applyReset();
		RST_N = 1'b0;
		repeat (2) @(posedge CLK);
		#2;
		RST_N = 1'b1;
	endtask

	// Each row holds the memory selects {cs3, dram, rom, sram}, {smpcCeN, scuWaitN, memWaitN}
	// and {bCs1N, bCs2N, bCssN, aCs2N}, then the expected cpu source (0 mem, 1 smpc, 2 scu),
	// waitN, B-bus source (0 vdp1, 1 vdp2, 2 scsp, 3 none) and whether the A-bus has cd data
	task automatic fillMuxTable();
		muxTable[0] = {4'b1111, 3'b111, 4'b1111, 2'd2, 1'b1, 2'd3, 1'b0};
		muxTable[1] = {4'b0111, 3'b111, 4'b0110, 2'd0, 1'b1, 2'd0, 1'b1};
		muxTable[2] = {4'b1011, 3'b010, 4'b1011, 2'd0, 1'b0, 2'd1, 1'b0};
		muxTable[3] = {4'b1101, 3'b101, 4'b1100, 2'd0, 1'b0, 2'd2, 1'b1};
		muxTable[4] = {4'b1110, 3'b110, 4'b0011, 2'd0, 1'b0, 2'd0, 1'b0};
		muxTable[5] = {4'b1111, 3'b010, 4'b1000, 2'd1, 1'b1, 2'd1, 1'b1};
		muxTable[6] = {4'b1111, 3'b001, 4'b1111, 2'd1, 1'b0, 2'd3, 1'b0};
		muxTable[7] = {4'b1111, 3'b110, 4'b0101, 2'd2, 1'b1, 2'd0, 1'b0};
		muxTable[8] = {4'b0000, 3'b011, 4'b1100, 2'd0, 1'b1, 2'd2, 1'b1};
		muxTable[9] = {4'b1111, 3'b100, 4'b1010, 2'd2, 1'b0, 2'd1, 1'b1};
	endtask

	task automatic checkReadMux();
		logic [16:0] row;
		logic [31:0] rnd;
		cpuDataT expData;
		bBusDataT expB;
		for (int i = 0; i < 10; i++) begin
			row = muxTable[i];
			nextCycle();
			{cpuCs3N, dramCeN, romCeN, sramCeN} = row[16:13];
			{smpcCeN, scuWaitN, memWaitN} = row[12:10];
			{bCs1N, bCs2N, bCssN, aCs2N} = row[9:6];
			memDataIn = nextRandom();
			scuData = nextRandom();
			rnd = nextRandom();
			{vdp1Data, vdp2Data} = rnd;
			rnd = nextRandom();
			{scspData, cdData} = rnd;
			rnd = nextRandom();
			smpcData = rnd[23:16];
			rnd = nextRandom();
			cpuDataOut = rnd;
			rnd = nextRandom();
			cpuAddr = rnd[31:7];
			rnd = nextRandom();
			cpuDqmN = rnd[31:28];
			cpuRdN = rnd[27];
			#1;
			case (row[5:4])
				2'd0: expData = memDataIn;
				2'd1: expData = {smpcData, smpcData, smpcData, smpcData};
				default: expData = scuData;
			endcase
			case (row[2:1])
				2'd0: expB = vdp1Data;
				2'd1: expB = vdp2Data;
				2'd2: expB = scspData;
				default: expB = '0;
			endcase
			checkValue($sformatf("cpuDataIn row %0d", i), expData, cpuDataIn);
			checkValue($sformatf("cpuWaitN row %0d", i), row[3], cpuWaitN);
			checkValue($sformatf("bDataIn row %0d", i), expB, bDataIn);
			checkValue($sformatf("aDataIn row %0d", i), row[0] ? cdData : 16'h0, aDataIn);
			checkValue($sformatf("chip selects row %0d", i),
				{romCeN, sramCeN, dramCeN, cpuCs3N}, {romCsN, sramCsN, ramlCsN, ramhCsN});
			checkValue($sformatf("memAddr row %0d", i), cpuAddr, memAddr);
			checkValue($sformatf("memDataOut row %0d", i), cpuDataOut, memDataOut);
			checkValue($sformatf("memDqmN row %0d", i), cpuDqmN, memDqmN);
			checkValue($sformatf("memRdN row %0d", i), cpuRdN, memRdN);
		end
		{cpuCs3N, dramCeN, romCeN, sramCeN, smpcCeN} = 5'b11111;
		{bCs1N, bCs2N, bCssN, aCs2N} = 4'b1111;
		{scuWaitN, memWaitN} = 2'b11;
		cpuAddr = '0;
		cpuDataOut = '0;
		cpuDqmN = 4'hF;
		cpuRdN = 1'b1;
	endtask

	task automatic checkPhaseEnables();
		logic expF;
		applyReset();
		ce = 1'b1;
		cdCe = 1'b1;
		// Falling phase leads out of reset
		expF = 1'b1;
		repeat (8) begin
			#1;
			checkValue("ceF phase", expF, ceF);
			checkValue("ceR phase", !expF, ceR);
			checkValue("cdCeF phase", expF, cdCeF);
			checkValue("cdCeR phase", !expF, cdCeR);
			nextCycle();
			expF = !expF;
		end
		cdCe = 1'b0;
		repeat (4) begin
			#1;
			checkValue("cdCeR off", 1'b0, cdCeR);
			checkValue("cdCeF off", 1'b0, cdCeF);
			nextCycle();
		end
	endtask

	task automatic checkPaused(input string testName);
		#1;
		checkValue({testName, " pause"}, 1'b1, pause);
		checkValue({testName, " ceR"}, 1'b0, ceR);
		checkValue({testName, " ceF"}, 1'b0, ceF);
		nextCycle();
	endtask

	task automatic checkRunControl();
		dbgPause = 1'b1;
		repeat (3) checkPaused("dbgPause");
		dbgPause = 1'b0;
		vdp1Start = 1'b1;
		dbgBreak = 1'b1;
		nextCycle();
		vdp1Start = 1'b0;
		repeat (4) checkPaused("break on vdp1Start");
		dbgRun = 1'b1;
		checkPaused("before run");
		dbgRun = 1'b0;
		#1;
		checkValue("pause after dbgRun", 1'b0, pause);
		nextCycle();
		vdp1CmdEnd = 1'b1;
		nextCycle();
		vdp1CmdEnd = 1'b0;
		checkPaused("break on vdp1CmdEnd");
		dbgRun = 1'b1;
		nextCycle();
		dbgRun = 1'b0;
		dbgBreak = 1'b0;
		#1;
		checkValue("pause after second dbgRun", 1'b0, pause);
		nextCycle();
	endtask

	task automatic checkSmpcDivider();
		int ceRCount;
		int pulses;
		int cycles;
		logic expPulse;
		logic expMres;
		applyReset();
		ceRCount = 0;
		pulses = 0;
		cycles = 0;
		expPulse = 1'b0;
		expMres = 1'b0;
		while (pulses < 2) begin
			#1;
			checkValue("smpcCe", expPulse, smpcCe);
			checkValue("mresN", expMres, mresN);
			if (expPulse) begin
				pulses++;
			end
			expMres = expMres | expPulse;
			if (ceR) begin
				ceRCount++;
			end
			expPulse = ceR && (ceRCount % 7 == 0);
			cycles++;
			if (cycles > waitLimit) begin
				reportFailure("smpcCe did not pulse twice within 200 cycles");
			end
			nextCycle();
		end
	endtask

	task automatic checkWaitCounter();
		waitCntT expCnt;
		int cycles;
		logic done;
		// Held read away from the hook address
		cpuAddr = 25'h0200000;
		cpuCs3N = 1'b0;
		cpuRdN = 1'b0;
		cpuDqmN = 4'h0;
		expCnt = '0;
		cycles = 0;
		while (expCnt < 8'd5) begin
			#1;
			checkValue("dbgWaitCnt busy", expCnt, dbgWaitCnt);
			checkValue("dbgHook other address", 1'b0, dbgHook);
			if (ceR) begin
				expCnt++;
			end
			cycles++;
			if (cycles > waitLimit) begin
				reportFailure("dbgWaitCnt never reached 5 within 200 cycles");
			end
			nextCycle();
		end
		cpuRdN = 1'b1;
		cpuDqmN = 4'hF;
		cpuCs3N = 1'b1;
		cycles = 0;
		done = 1'b0;
		while (!done) begin
			#1;
			checkValue("dbgWaitCnt idle", expCnt, dbgWaitCnt);
			done = (expCnt == 8'd0);
			if (ceR) begin
				expCnt = '0;
			end
			cycles++;
			if (cycles > waitLimit) begin
				reportFailure("dbgWaitCnt never cleared within 200 cycles");
			end
			nextCycle();
		end
	endtask

	task automatic checkBootHook();
		logic expHook;
		logic done;
		int cycles;
		cpuAddr = 25'h00012B0;
		cpuRdN = 1'b0;
		cpuCs3N = 1'b1;
		repeat (6) begin
			#1;
			checkValue("dbgHook without cs3", 1'b0, dbgHook);
			nextCycle();
		end
		cpuCs3N = 1'b0;
		expHook = 1'b0;
		done = 1'b0;
		cycles = 0;
		while (!done) begin
			#1;
			checkValue("dbgHook set", expHook, dbgHook);
			done = expHook;
			if (ceR) begin
				expHook = 1'b1;
			end
			cycles++;
			if (cycles > waitLimit) begin
				reportFailure("dbgHook never set within 200 cycles");
			end
			nextCycle();
		end
		cpuAddr = 25'h0200000;
		cpuRdN = 1'b1;
		cpuCs3N = 1'b1;
		repeat (4) begin
			#1;
			checkValue("dbgHook sticky", 1'b1, dbgHook);
			nextCycle();
		end
	endtask

	initial begin
		RST_N = 1'b0;
		ce = 1'b0;
		cdCe = 1'b0;
		dbgPause = 1'b0;
		dbgBreak = 1'b0;
		dbgRun = 1'b0;
		vdp1Start = 1'b0;
		vdp1CmdEnd = 1'b0;
		cpuAddr = '0;
		cpuDataOut = '0;
		cpuDqmN = 4'hF;
		cpuRdN = 1'b1;
		{cpuCs3N, dramCeN, romCeN, sramCeN, smpcCeN} = 5'b11111;
		memDataIn = '0;
		scuData = '0;
		smpcData = '0;
		{scuWaitN, memWaitN} = 2'b11;
		{bCs1N, bCs2N, bCssN, aCs2N} = 4'b1111;
		vdp1Data = '0;
		vdp2Data = '0;
		scspData = '0;
		cdData = '0;
		lcgState = 32'd74;
		fillMuxTable();
		applyReset();
		checkReadMux();
		checkPhaseEnables();
		checkRunControl();
		checkSmpcDivider();
		checkWaitCounter();
		checkBootHook();
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* src.f */
hw/saturnBusPkg.sv
hw/saturnCtrlPkg.sv
hw/clockEnableGen.sv
hw/smpcClockDiv.sv
hw/busReadMux.sv
hw/debugMonitor.sv
hw/saturnGlue.sv
tests/saturnGlueTb.sv
